// ==== lsu_pkg.sv ====
// LSU shared definitions
// widths, access size encoding and the packed payload structs
// passed between the core, the unit and the data bus
package lsu_pkg;

  localparam int unsigned DataWidth = 32;            // bus data word
  localparam int unsigned BeWidth   = DataWidth / 8; // byte lanes per word

  // access size as decoded by the core
  // code 2'b11 is never issued, decoders treat it as a byte
  typedef enum logic [1:0] {
    LSU_WORD = 2'b00,
    LSU_HALF = 2'b01,
    LSU_BYTE = 2'b10
  } lsu_size_e;

  //////////////////////////////
  // core side
  //////////////////////////////

  // request payload, address travels beside it
  typedef struct packed {
    logic                 we;       // store when set
    lsu_size_e            size;
    logic                 sign_ext; // sign extend loaded half / byte
    logic [DataWidth-1:0] wdata;    // store data, lsb aligned
  } lsu_req_t;                      // 36 bits

  // response of a finished access, one cycle pulse
  typedef struct packed {
    logic [DataWidth-1:0] rdata;    // extended load data
    logic                 err;      // either part saw a bus error
    logic                 we;       // access was a store
  } lsu_resp_t;                     // 34 bits

  //////////////////////////////
  // bus side
  //////////////////////////////

  // one word aligned bus part, address travels beside it
  typedef struct packed {
    logic                 we;
    logic [BeWidth-1:0]   be;       // byte lane enables
    logic [DataWidth-1:0] wdata;    // data already on its lanes
  } lsu_bus_req_t;                  // 37 bits

endpackage

// ==== lsu_store_align.sv ====
// LSU store aligner
// rotates store data onto the bus byte lanes and selects the byte
// enables of the first or second part of an access
`timescale 1ns/1ps

module lsu_store_align import lsu_pkg::*; (
  input  lsu_req_t     req_i,         // held by the core until accepted
  input  logic [1:0]   offset_i,      // low address bits
  input  logic         second_part_i, // second word of a split access
  output lsu_bus_req_t bus_pl_o
);

  logic [BeWidth-1:0]   be;
  logic [DataWidth-1:0] wdata_rot;

  //////////////////////////////
  // byte enables
  //////////////////////////////

  // first part covers offset upward, second part the spill below it
  always_comb begin
    unique case (req_i.size)
      LSU_WORD: begin
        if (!second_part_i) begin
          be = {BeWidth{1'b1}} << offset_i;    // 1111 1110 1100 1000
        end else begin
          be = ~({BeWidth{1'b1}} << offset_i); // 0001 0011 0111 spill
        end
      end

      LSU_HALF: begin
        if (!second_part_i) begin
          be = 4'b0011 << offset_i;  // offset 3 keeps only lane 3
        end else begin
          be = 4'b0001;              // upper byte of a half at offset 3
        end
      end

      default: begin
        be = 4'b0001 << offset_i;    // byte, never split
      end
    endcase
  end

  //////////////////////////////
  // write data rotation
  //////////////////////////////

  // rotate left by the byte offset
  // bytes wrapping past lane 3 land in the low lanes for the second part
  always_comb begin
    unique case (offset_i)
      2'b00:   wdata_rot = req_i.wdata;
      2'b01:   wdata_rot = {req_i.wdata[23:0], req_i.wdata[31:24]};
      2'b10:   wdata_rot = {req_i.wdata[15:0], req_i.wdata[31:16]};
      default: wdata_rot = {req_i.wdata[7:0], req_i.wdata[31:8]};
    endcase
  end

  // same rotated word serves both parts, enables pick the lanes
  assign bus_pl_o = '{
    we:    req_i.we,
    be:    be,
    wdata: wdata_rot
  };

endmodule

// ==== lsu_load_align.sv ====
// LSU load aligner
// keeps the attributes of the access in flight, holds the first word
// of a split load and assembles and extends the returned data
`timescale 1ns/1ps

module lsu_load_align import lsu_pkg::*; (
  input  logic                 clk_i,
  input  logic                 rst_ni,
  input  logic                 attr_update_i,   // first grant of an access
  input  logic                 first_capture_i, // first part response of a split
  input  logic                 final_resp_i,    // response of the last part
  input  lsu_req_t             req_i,
  input  logic [1:0]           offset_i,
  input  logic [DataWidth-1:0] bus_rdata_i,
  output logic [DataWidth-1:0] rdata_o,
  output logic                 we_o              // write flag of the access
);

  logic [1:0]           offset_q;
  lsu_size_e            size_q;
  logic                 sext_q;
  logic                 we_q;
  logic [31:8]          rdata_q;   // upper three bytes of the first word
  logic [DataWidth-1:0] word_data;
  logic [15:0]          half_data;
  logic [7:0]           byte_data;
  logic [DataWidth-1:0] rdata_ext;

  //////////////////////////////
  // access attributes
  //////////////////////////////

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      offset_q <= 2'b00;
      size_q   <= LSU_WORD;
      sext_q   <= 1'b0;
      we_q     <= 1'b0;
    end else if (attr_update_i) begin
      offset_q <= offset_i;
      size_q   <= req_i.size;
      sext_q   <= req_i.sign_ext;
      we_q     <= req_i.we;
    end
  end

  // lane 0 of the first word is never part of a split result
  always_ff @(posedge clk_i) begin
    if (first_capture_i && !we_q) begin
      rdata_q <= bus_rdata_i[31:8];
    end
  end

  //////////////////////////////
  // realignment
  //////////////////////////////

  // split words take their low bytes from the held first word
  always_comb begin
    unique case (offset_q)
      2'b00:   word_data = bus_rdata_i;
      2'b01:   word_data = {bus_rdata_i[7:0], rdata_q[31:8]};
      2'b10:   word_data = {bus_rdata_i[15:0], rdata_q[31:16]};
      default: word_data = {bus_rdata_i[23:0], rdata_q[31:24]};
    endcase
  end

  always_comb begin
    unique case (offset_q)
      2'b00:   half_data = bus_rdata_i[15:0];
      2'b01:   half_data = bus_rdata_i[23:8];
      2'b10:   half_data = bus_rdata_i[31:16];
      default: half_data = {bus_rdata_i[7:0], rdata_q[31:24]}; // split half
    endcase
  end

  assign byte_data = bus_rdata_i[8*offset_q +: 8]; // bytes are never split

  //////////////////////////////
  // extension
  //////////////////////////////

  always_comb begin
    unique case (size_q)
      LSU_WORD: rdata_ext = word_data;
      LSU_HALF: rdata_ext = {{16{sext_q & half_data[15]}}, half_data};
      default:  rdata_ext = {{24{sext_q & byte_data[7]}}, byte_data};
    endcase
  end

  // quiet between responses, bus data is only valid with rvalid
  assign rdata_o = final_resp_i ? rdata_ext : '0;
  assign we_o    = we_q;

  // selectors of the data muxes must always be known
  a_attr_known: assert property (@(posedge clk_i) disable iff (!rst_ni)
    !$isunknown({size_q, offset_q}));

endmodule

// ==== lsu_ctrl.sv ====
// LSU controller
// sequences the one or two bus parts of an access, tracks the owed
// response, collects part errors and drives the core handshakes
`timescale 1ns/1ps

module lsu_ctrl import lsu_pkg::*; #(
  parameter int unsigned AddrWidth = 32
) (
  input  logic                 clk_i,
  input  logic                 rst_ni,
  input  logic                 req_valid_i,
  input  lsu_req_t             req_i,
  input  logic [AddrWidth-1:0] req_addr_i,
  output logic                 req_ready_o,     // last part granted
  output logic                 bus_req_o,
  output logic [AddrWidth-1:0] bus_addr_o,      // word aligned
  input  logic                 bus_gnt_i,
  input  logic                 bus_rvalid_i,
  input  logic                 bus_err_i,
  output logic                 second_part_o,
  output logic                 attr_update_o,
  output logic                 first_capture_o,
  output logic                 final_resp_o,
  output logic                 resp_valid_o,
  output logic                 resp_err_o,
  output logic [AddrWidth-1:0] err_addr_o,
  output logic                 busy_o
);

  typedef enum logic [2:0] {
    IDLE,             // no part requested
    WAIT_GNT_MIS,     // first part of a split waits for grant
    WAIT_RVALID_MIS,  // second part requested, first response owed
    WAIT_GNT,         // single or second part waits for grant
    WAIT_RVALID_DONE  // both granted, first response owed
  } ctrl_state_e;

  ctrl_state_e          state_q, state_d;
  logic                 pending_q, pending_d;     // final response still owed
  logic                 second_q, second_d;       // second part is being requested
  logic                 err_first_q, err_first_d; // first part failed
  logic                 split_q;                  // access in flight is split
  logic [AddrWidth-1:0] addr_q;                   // original request address
  logic [AddrWidth-3:0] word_next;                // word index of the second part
  logic                 split;
  logic                 final_resp;

  // word not on a word boundary, or half crossing into the next word
  assign split = ((req_i.size == LSU_WORD) && (req_addr_i[1:0] != 2'b00)) ||
                 ((req_i.size == LSU_HALF) && (req_addr_i[1:0] == 2'b11));

  assign word_next  = addr_q[AddrWidth-1:2] + 1'b1;
  assign final_resp = bus_rvalid_i & pending_q & (state_q == IDLE);

  //////////////////////////////
  // FSM
  //////////////////////////////

  always_comb begin
    state_d         = state_q;
    second_d        = second_q;
    err_first_d     = err_first_q;
    bus_req_o       = 1'b0;
    req_ready_o     = 1'b0;
    attr_update_o   = 1'b0;
    first_capture_o = 1'b0;

    unique case (state_q)
      IDLE: begin
        // hold off a new access until the owed response is back
        if (req_valid_i && !pending_q) begin
          bus_req_o = 1'b1;
          if (bus_gnt_i) begin
            attr_update_o = 1'b1;
            err_first_d   = 1'b0;
            second_d      = split;
            req_ready_o   = ~split;  // single part done at its grant
            state_d       = split ? WAIT_RVALID_MIS : IDLE;
          end else begin
            state_d = split ? WAIT_GNT_MIS : WAIT_GNT;
          end
        end
      end

      WAIT_GNT_MIS: begin
        bus_req_o = 1'b1;
        if (bus_gnt_i) begin
          attr_update_o = 1'b1;
          err_first_d   = 1'b0;
          second_d      = 1'b1;
          state_d       = WAIT_RVALID_MIS;
        end
      end

      WAIT_RVALID_MIS: begin
        bus_req_o = 1'b1;  // second part goes out right away
        if (bus_rvalid_i) begin
          first_capture_o = 1'b1;
          err_first_d     = bus_err_i;
        end
        if (bus_gnt_i) begin
          req_ready_o = 1'b1;
          second_d    = 1'b0;
          state_d     = bus_rvalid_i ? IDLE : WAIT_RVALID_DONE;
        end else if (bus_rvalid_i) begin
          state_d = WAIT_GNT;
        end
      end

      WAIT_GNT: begin
        bus_req_o = 1'b1;
        if (bus_gnt_i) begin
          if (!second_q) begin  // grant of a single part access
            attr_update_o = 1'b1;
            err_first_d   = 1'b0;
          end
          req_ready_o = 1'b1;
          second_d    = 1'b0;
          state_d     = IDLE;
        end
      end

      WAIT_RVALID_DONE: begin
        if (bus_rvalid_i) begin
          first_capture_o = 1'b1;
          err_first_d     = bus_err_i;
          state_d         = IDLE;  // second response follows in IDLE
        end
      end

      default: state_d = IDLE;
    endcase
  end

  assign pending_d = req_ready_o | (pending_q & ~final_resp);

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q     <= IDLE;
      pending_q   <= 1'b0;
      second_q    <= 1'b0;
      err_first_q <= 1'b0;
      split_q     <= 1'b0;
    end else begin
      state_q     <= state_d;
      pending_q   <= pending_d;
      second_q    <= second_d;
      err_first_q <= err_first_d;
      if (attr_update_o) begin
        split_q <= split;
      end
    end
  end

  // base for the second word and the error address
  always_ff @(posedge clk_i) begin
    if (attr_update_o) begin
      addr_q <= req_addr_i;
    end
  end

  //////////////////////////////
  // outputs
  //////////////////////////////

  assign bus_addr_o = second_q ? {word_next, 2'b00} : {req_addr_i[AddrWidth-1:2], 2'b00};

  assign second_part_o = second_q;
  assign final_resp_o  = final_resp;
  assign resp_valid_o  = final_resp;
  assign resp_err_o    = final_resp & (bus_err_i | err_first_q);

  // first failing part wins, a clean first part points at the second word
  assign err_addr_o = (split_q && !err_first_q) ? {word_next, 2'b00} : addr_q;

  assign busy_o = pending_q | (state_q != IDLE);

  a_state_legal: assert property (@(posedge clk_i) disable iff (!rst_ni)
    state_q inside {IDLE, WAIT_GNT_MIS, WAIT_RVALID_MIS, WAIT_GNT, WAIT_RVALID_DONE});

  a_err_with_rvalid: assert property (@(posedge clk_i) disable iff (!rst_ni)
    bus_err_i |-> bus_rvalid_i);

  a_bus_addr_ok: assert property (@(posedge clk_i) disable iff (!rst_ni)
    bus_req_o |-> (!$isunknown(bus_addr_o) && (bus_addr_o[1:0] == 2'b00)));

endmodule

// ==== lsu_top.sv ====
// LSU top level
// joins the controller and the store and load aligners between the
// execute stage request port and the request/grant/response data bus
`timescale 1ns/1ps

module lsu_top import lsu_pkg::*; #(
  parameter int unsigned AddrWidth = 32
) (
  input  logic                 clk_i,
  input  logic                 rst_ni,
  // core request
  input  logic                 req_valid_i,
  output logic                 req_ready_o,
  input  lsu_req_t             req_i,
  input  logic [AddrWidth-1:0] req_addr_i,
  // core response, no back-pressure
  output logic                 resp_valid_o,
  output lsu_resp_t            resp_o,
  output logic [AddrWidth-1:0] err_addr_o,
  // data bus
  output logic                 bus_req_o,
  output logic [AddrWidth-1:0] bus_addr_o,
  output lsu_bus_req_t         bus_req_pl_o,
  input  logic                 bus_gnt_i,
  input  logic                 bus_rvalid_i,
  input  logic [DataWidth-1:0] bus_rdata_i,
  input  logic                 bus_err_i,
  output logic                 busy_o
);

  logic                 second_part;
  logic                 attr_update;
  logic                 first_capture;
  logic                 final_resp;
  logic                 resp_err;
  logic                 resp_we;
  logic [DataWidth-1:0] rdata;

  lsu_ctrl #(
    .AddrWidth (AddrWidth)
  ) u_ctrl (
    .clk_i           (clk_i),
    .rst_ni          (rst_ni),
    .req_valid_i     (req_valid_i),
    .req_i           (req_i),
    .req_addr_i      (req_addr_i),
    .req_ready_o     (req_ready_o),
    .bus_req_o       (bus_req_o),
    .bus_addr_o      (bus_addr_o),
    .bus_gnt_i       (bus_gnt_i),
    .bus_rvalid_i    (bus_rvalid_i),
    .bus_err_i       (bus_err_i),
    .second_part_o   (second_part),
    .attr_update_o   (attr_update),
    .first_capture_o (first_capture),
    .final_resp_o    (final_resp),
    .resp_valid_o    (resp_valid_o),
    .resp_err_o      (resp_err),
    .err_addr_o      (err_addr_o),
    .busy_o          (busy_o)
  );

  // core holds the payload until the last grant, so both parts see it
  lsu_store_align u_store_align (
    .req_i         (req_i),
    .offset_i      (req_addr_i[1:0]),
    .second_part_i (second_part),
    .bus_pl_o      (bus_req_pl_o)
  );

  lsu_load_align u_load_align (
    .clk_i           (clk_i),
    .rst_ni          (rst_ni),
    .attr_update_i   (attr_update),
    .first_capture_i (first_capture),
    .final_resp_i    (final_resp),
    .req_i           (req_i),
    .offset_i        (req_addr_i[1:0]),
    .bus_rdata_i     (bus_rdata_i),
    .rdata_o         (rdata),
    .we_o            (resp_we)
  );

  assign resp_o = '{rdata: rdata, err: resp_err, we: resp_we};

  // a second part is only requested for a split access, so some lane is enabled
  a_be_nonzero: assert property (@(posedge clk_i) disable iff (!rst_ni)
    bus_req_o |-> (bus_req_pl_o.be != '0));

endmodule

// ==== tb_lsu_mem.sv ====
// testbench bus responder
// byte memory behind a request/grant/response bus, with random grant
// and response delays, in-order responses and error injection per word
`timescale 1ns/1ps

module tb_lsu_mem import lsu_pkg::*; (
  input  logic                 clk_i,
  input  logic                 rst_ni,
  input  logic                 req_i,
  input  logic [31:0]          addr_i,     // word aligned
  input  lsu_bus_req_t         pl_i,
  output logic                 gnt_o,
  output logic                 rvalid_o,
  output logic [DataWidth-1:0] rdata_o,
  output logic                 err_o,
  input  logic                 err_en_i,   // fail accesses to err_word_i
  input  logic [29:0]          err_word_i,
  output int unsigned          txn_cnt_o,  // granted parts
  output int unsigned          max_out_o   // most parts in flight at a grant
);

  typedef struct packed {
    logic [31:0] data;
    logic        err;
    logic [31:0] due;    // edge at which rvalid is raised
  } rsp_t;

  logic [7:0]           mem [1024];
  rsp_t                 rsp_q [$];     // granted, response not yet driven
  int unsigned          wait_q;        // cycles the current part waited
  int unsigned          gnt_dly_q;     // grant delay of the current part
  int unsigned          edge_cnt;
  int unsigned          last_due;
  logic                 rvalid_q;
  logic                 err_q;
  logic [DataWidth-1:0] rdata_q;

  // same pattern as the shadow memory of the testbench
  initial begin
    for (int i = 0; i < 1024; i++) begin
      mem[i] = 8'((i * 37) ^ (i >> 5));
    end
  end

  assign gnt_o    = req_i && (wait_q >= gnt_dly_q);
  assign rvalid_o = rvalid_q;
  assign rdata_o  = rdata_q;
  assign err_o    = err_q;         // only ever set together with rvalid

  //////////////////////////////
  // grant and response
  //////////////////////////////

  always @(posedge clk_i or negedge rst_ni) begin
    rsp_t        rsp;
    logic [9:0]  base;
    int unsigned due;
    if (!rst_ni) begin
      wait_q    <= 0;
      gnt_dly_q <= $urandom_range(3, 0);
      rvalid_q  <= 1'b0;
      err_q     <= 1'b0;
      rdata_q   <= '0;
      rsp_q.delete();
      edge_cnt  = 0;
      last_due  = 0;
      txn_cnt_o = 0;
      max_out_o = 0;
    end else begin
      edge_cnt = edge_cnt + 1;
      if (req_i && gnt_o) begin
        base     = {addr_i[9:2], 2'b00};
        rsp.err  = err_en_i && (addr_i[31:2] == err_word_i);
        rsp.data = {mem[base + 3], mem[base + 2], mem[base + 1], mem[base]};
        if (pl_i.we && !rsp.err) begin   // failed stores leave memory alone
          for (int b = 0; b < BeWidth; b++) begin
            if (pl_i.be[b]) mem[base + b] = pl_i.wdata[8*b +: 8];
          end
        end
        due = edge_cnt + $urandom_range(3, 0);
        if (due <= last_due) due = last_due + 1;  // keep issue order
        last_due = due;
        rsp.due  = due;
        if (rsp_q.size() + 1 > max_out_o) max_out_o = rsp_q.size() + 1;
        rsp_q.push_back(rsp);
        txn_cnt_o = txn_cnt_o + 1;
        wait_q    <= 0;
        gnt_dly_q <= $urandom_range(3, 0);
      end else if (req_i) begin
        wait_q <= wait_q + 1;
      end
      rvalid_q <= 1'b0;
      err_q    <= 1'b0;
      rdata_q  <= '0;
      if ((rsp_q.size() > 0) && (rsp_q[0].due <= edge_cnt)) begin
        rsp      = rsp_q.pop_front();
        rvalid_q <= 1'b1;
        rdata_q  <= rsp.data;
        err_q    <= rsp.err;
      end
    end
  end

endmodule

// ==== tb_lsu.sv ====
// LSU testbench
// directed tests against a byte shadow memory, a response monitor that
// matches every resp_valid pulse to the accepted access, and a watchdog
`timescale 1ns/1ps

module tb_lsu import lsu_pkg::*;;

  localparam int unsigned AddrWidth   = 32;
  localparam int unsigned NumAccesses = 23 + 15 + 12 + 40 + 5; // sum over the tests

  typedef struct packed {
    logic        we;
    logic        chk_data;  // loads without error
    logic [31:0] addr;
    logic [31:0] rdata;
    logic        err;
    logic [31:0] err_addr;
  } expect_t;

  logic         clk_i = 1'b0;
  logic         rst_ni;
  logic         req_valid;
  logic         req_ready;
  lsu_req_t     req;
  logic [31:0]  req_addr;
  logic         resp_valid;
  lsu_resp_t    resp;
  logic [31:0]  err_addr;
  logic         bus_req;
  logic [31:0]  bus_addr;
  lsu_bus_req_t bus_pl;
  logic         bus_gnt;
  logic         bus_rvalid;
  logic [31:0]  bus_rdata;
  logic         bus_err;
  logic         busy;
  logic         err_en;
  logic [29:0]  err_word;
  int unsigned  txn_cnt;
  int unsigned  max_out;

  logic [7:0]   shadow [1024];  // reference memory
  expect_t      exp_q [$];      // accepted with response owed
  int unsigned  errors    = 0;
  int unsigned  accepted  = 0;
  int unsigned  responses = 0;

  always #5 clk_i = ~clk_i;

  lsu_top #(
    .AddrWidth (AddrWidth)
  ) DUT (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .req_valid_i  (req_valid),
    .req_ready_o  (req_ready),
    .req_i        (req),
    .req_addr_i   (req_addr),
    .resp_valid_o (resp_valid),
    .resp_o       (resp),
    .err_addr_o   (err_addr),
    .bus_req_o    (bus_req),
    .bus_addr_o   (bus_addr),
    .bus_req_pl_o (bus_pl),
    .bus_gnt_i    (bus_gnt),
    .bus_rvalid_i (bus_rvalid),
    .bus_rdata_i  (bus_rdata),
    .bus_err_i    (bus_err),
    .busy_o       (busy)
  );

  tb_lsu_mem u_mem (
    .clk_i      (clk_i),
    .rst_ni     (rst_ni),
    .req_i      (bus_req),
    .addr_i     (bus_addr),
    .pl_i       (bus_pl),
    .gnt_o      (bus_gnt),
    .rvalid_o   (bus_rvalid),
    .rdata_o    (bus_rdata),
    .err_o      (bus_err),
    .err_en_i   (err_en),
    .err_word_i (err_word),
    .txn_cnt_o  (txn_cnt),
    .max_out_o  (max_out)
  );

  //////////////////////////////
  // reference model
  //////////////////////////////

  function automatic logic [7:0] fill_byte(int unsigned a);
    return 8'((a * 37) ^ (a >> 5));
  endfunction

  // word off its boundary, or half crossing into the next word
  function automatic logic split_access(lsu_size_e size, logic [31:0] addr);
    return ((size == LSU_WORD) && (addr[1:0] != 2'b00)) ||
           ((size == LSU_HALF) && (addr[1:0] == 2'b11));
  endfunction

  // little endian read of the shadow memory with extension
  function automatic logic [31:0] ref_load(lsu_size_e size, logic sext, logic [31:0] addr);
    int unsigned a;
    logic [31:0] w;
    a = addr[9:0];
    w = {shadow[a + 3], shadow[a + 2], shadow[a + 1], shadow[a]};
    case (size)
      LSU_WORD: return w;
      LSU_HALF: return {{16{sext & w[15]}}, w[15:0]};
      default:  return {{24{sext & w[7]}}, w[7:0]};
    endcase
  endfunction

  task automatic check_val(string what, logic [31:0] exp, logic [31:0] act);
    if (exp !== act) begin
      errors++;
      $display("Fail %0t ns: %s, expected %h, got %h", $time, what, exp, act);
    end
  endtask

  //////////////////////////////
  // access tasks
  //////////////////////////////

  // drives one request and returns one ns after the edge that accepts it
  task automatic issue_access(logic we, lsu_size_e size, logic sext, logic [31:0] addr,
                              logic [31:0] wdata, logic exp_err, logic [31:0] exp_eaddr);
    expect_t     exp;
    int          nbytes;
    int unsigned n0;
    n0           = txn_cnt;
    exp.we       = we;
    exp.chk_data = !we && !exp_err;
    exp.addr     = addr;
    exp.rdata    = ref_load(size, sext, addr);
    exp.err      = exp_err;
    exp.err_addr = exp_eaddr;
    req.we       = we;
    req.size     = size;
    req.sign_ext = sext;
    req.wdata    = wdata;
    req_addr     = addr;
    req_valid    = 1'b1;
    do @(negedge clk_i); while (!req_ready);
    check_val($sformatf("ready only with final grant at %h", addr), 1, bus_req & bus_gnt);
    // a split has its first part granted before the accepting grant
    check_val($sformatf("parts granted before acceptance at %h", addr),
              split_access(size, addr) ? 1 : 0, txn_cnt - n0);
    exp_q.push_back(exp);
    accepted++;
    if (we && !exp_err) begin
      nbytes = (size == LSU_WORD) ? 4 : (size == LSU_HALF) ? 2 : 1;
      for (int i = 0; i < nbytes; i++) shadow[addr[9:0] + i] = wdata[8*i +: 8];
    end
    @(posedge clk_i);
    #1 req_valid = 1'b0;
    check_val($sformatf("busy while response owed at %h", addr), 1, busy);
  endtask

  // wait for every owed response and expect an idle unit
  task automatic drain_responses();
    while (exp_q.size() != 0) @(negedge clk_i);
    @(negedge clk_i);
    check_val("busy after drain", 0, busy);
    check_val("req_ready without request", 0, req_ready);
    @(posedge clk_i);
    #1;
  endtask

  task automatic run_access(logic we, lsu_size_e size, logic sext, logic [31:0] addr,
                            logic [31:0] wdata);
    int unsigned n0;
    n0 = txn_cnt;
    issue_access(we, size, sext, addr, wdata, 1'b0, 32'h0);
    drain_responses();
    check_val($sformatf("bus parts for %h", addr), split_access(size, addr) ? 2 : 1,
              txn_cnt - n0);
  endtask

  //////////////////////////////
  // tests
  //////////////////////////////

  task automatic apply_reset();
    rst_ni    = 1'b0;
    req_valid = 1'b0;
    repeat (5) @(posedge clk_i);
    #1 rst_ni = 1'b1;
    @(negedge clk_i);
    check_val("busy after reset", 0, busy);
    check_val("req_ready after reset", 0, req_ready);
    check_val("bus_req after reset", 0, bus_req);
    check_val("resp_valid after reset", 0, resp_valid);
    @(posedge clk_i);
    #1;
  endtask

  task automatic aligned_stores();
    run_access(1'b1, LSU_WORD, 1'b0, 32'h100, 32'h1122_3344);
    run_access(1'b0, LSU_WORD, 1'b0, 32'h100, '0);
    for (int off = 0; off < 3; off++) begin
      run_access(1'b1, LSU_HALF, 1'b0, 32'h104 + off, 32'h0000_9A00 + off);
      run_access(1'b0, LSU_HALF, 1'b0, 32'h104 + off, '0);
      run_access(1'b0, LSU_WORD, 1'b0, 32'h104, '0);  // neighbours untouched
    end
    for (int off = 0; off < 4; off++) begin
      run_access(1'b1, LSU_BYTE, 1'b0, 32'h108 + off, 32'h0000_00C0 + off);
      run_access(1'b0, LSU_BYTE, 1'b0, 32'h108 + off, '0);
      run_access(1'b0, LSU_WORD, 1'b0, 32'h108, '0);
    end
  endtask

  task automatic sign_extension();
    run_access(1'b1, LSU_WORD, 1'b0, 32'h200, 32'h80F1_7F85);  // mixed top bits
    for (int off = 0; off < 4; off++) begin
      for (int s = 0; s < 2; s++) run_access(1'b0, LSU_BYTE, 1'(s), 32'h200 + off, '0);
    end
    for (int off = 0; off < 3; off++) begin
      for (int s = 0; s < 2; s++) run_access(1'b0, LSU_HALF, 1'(s), 32'h200 + off, '0);
    end
  endtask

  task automatic misaligned_accesses();
    logic [31:0] addr;
    for (int off = 1; off < 4; off++) begin
      addr = 32'h280 + 8 * off + off;
      run_access(1'b1, LSU_WORD, 1'b0, addr, 32'hA1B2_C3D4 ^ off);
      run_access(1'b0, LSU_WORD, 1'b0, addr, '0);
      run_access(1'b0, LSU_WORD, 1'b0, {addr[31:2], 2'b00} + 4, '0);  // spill word
    end
    run_access(1'b1, LSU_HALF, 1'b0, 32'h2A3, 32'h0000_C3A5);
    run_access(1'b0, LSU_HALF, 1'b0, 32'h2A3, '0);
    run_access(1'b0, LSU_HALF, 1'b1, 32'h2A3, '0);
  endtask

  // requests follow each other with no gap and the monitor checks responses
  task automatic back_to_back();
    lsu_size_e   size;
    logic        we;
    logic        sext;
    logic [31:0] addr;
    for (int n = 0; n < 40; n++) begin
      size = lsu_size_e'(2'($urandom_range(2, 0)));
      we   = 1'($urandom_range(1, 0));
      sext = 1'($urandom_range(1, 0));
      addr = 32'h300 + $urandom_range(32'hEB, 0);
      issue_access(we, size, sext, addr, $urandom(), 1'b0, 32'h0);
    end
    drain_responses();
    check_val("second grant before first response seen", 1, max_out >= 2);
  endtask

  task automatic error_injection();
    err_en   = 1'b1;
    err_word = 30'(32'h3F0 >> 2);    // first part of the split
    issue_access(1'b0, LSU_WORD, 1'b0, 32'h3F1, '0, 1'b1, 32'h3F1);
    drain_responses();
    err_word = 30'(32'h3F4 >> 2);    // second part only
    issue_access(1'b0, LSU_WORD, 1'b0, 32'h3F1, '0, 1'b1, 32'h3F4);
    drain_responses();
    err_word = 30'(32'h3E8 >> 2);    // single part accesses
    issue_access(1'b0, LSU_WORD, 1'b0, 32'h3E8, '0, 1'b1, 32'h3E8);
    drain_responses();
    issue_access(1'b0, LSU_BYTE, 1'b0, 32'h3E9, '0, 1'b1, 32'h3E9);
    drain_responses();
    err_en = 1'b0;
    run_access(1'b0, LSU_WORD, 1'b0, 32'h3F1, '0);  // clean again
  endtask

  //////////////////////////////
  // monitor, main, watchdog
  //////////////////////////////

  always @(negedge clk_i) begin
    expect_t exp;
    if (rst_ni && resp_valid) begin
      responses++;
      if (exp_q.size() == 0) begin
        errors++;
        $display("response at %0t ns with no access outstanding", $time);
      end else begin
        exp = exp_q.pop_front();
        check_val($sformatf("err flag at %h", exp.addr), exp.err, resp.err);
        check_val($sformatf("write flag at %h", exp.addr), exp.we, resp.we);
        if (exp.chk_data) begin
          check_val($sformatf("load data at %h", exp.addr), exp.rdata, resp.rdata);
        end
        if (exp.err) begin
          check_val($sformatf("error address for %h", exp.addr), exp.err_addr, err_addr);
        end
      end
    end
  end

  initial begin
    void'($urandom(74624));
    rst_ni    = 1'b0;
    req_valid = 1'b0;
    req       = '0;
    req_addr  = '0;
    err_en    = 1'b0;
    err_word  = '0;
    for (int i = 0; i < 1024; i++) shadow[i] = fill_byte(i);
    apply_reset();
    aligned_stores();
    sign_extension();
    misaligned_accesses();
    back_to_back();
    error_injection();
    drain_responses();
    check_val("one response per accepted request", accepted, responses);
    $display("%0d errors, %0d accesses accepted, %0d responses", errors, accepted, responses);
    if (errors == 0) begin
      $display("Simulation passed");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

  // about 200 cycles per access over the whole run
  initial begin
    repeat (NumAccesses * 200) @(posedge clk_i);
    $display("watchdog expired after %0d cycles, the run hung", NumAccesses * 200);
    $display("Simulation failed");
    $finish;
  end

endmodule

// ==== verilog.f ====
lsu_pkg.sv
lsu_store_align.sv
lsu_load_align.sv
lsu_ctrl.sv
lsu_top.sv
tb_lsu_mem.sv
tb_lsu.sv

// ==== Bender.yml ====
package:
  name: lsu

sources:
  - lsu_pkg.sv
  - lsu_store_align.sv
  - lsu_load_align.sv
  - lsu_ctrl.sv
  - lsu_top.sv
  - target: test
    files:
      - tb_lsu_mem.sv
      - tb_lsu.sv
